//--- src/rec_pkg.sv
// Shared widths, command codes, register indices and reset constants, referenced by scoped name
`default_nettype none

package rec_pkg;

  // Data widths
  typedef logic [31:0] word_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] len_t;

  // Recovery command codes
  typedef enum logic [7:0] {
    CMD_PROT_CAP        = 8'd34,
    CMD_DEVICE_STATUS   = 8'd36,
    CMD_DEVICE_RESET    = 8'd37,
    CMD_RECOVERY_CTRL   = 8'd38,
    CMD_RECOVERY_STATUS = 8'd39
  } cmd_e;

  // Word index into the register bank
  typedef enum logic [3:0] {
    CSR_PROT_CAP_0      = 4'd0,
    CSR_PROT_CAP_1      = 4'd1,
    CSR_PROT_CAP_2      = 4'd2,
    CSR_PROT_CAP_3      = 4'd3,
    CSR_DEVICE_STATUS_0 = 4'd4,
    CSR_DEVICE_STATUS_1 = 4'd5,
    CSR_DEVICE_RESET    = 4'd6,
    CSR_RECOVERY_CTRL   = 4'd7,
    CSR_RECOVERY_STATUS = 4'd8,
    CSR_INVALID         = 4'd15
  } csr_idx_e;

  // Protocol status codes for DEVICE_STATUS byte 1
  typedef enum logic [7:0] {
    PROTO_OK        = 8'd0,
    PROTO_ERROR_CRC = 8'd4
  } proto_e;

  localparam int unsigned CSR_WORDS = 9;

  // Capability words, "OCP RECV" magic first
  localparam word_t PROT_CAP_WORD0 = 32'h2050_434F;
  localparam word_t PROT_CAP_WORD1 = 32'h5643_4552;
  localparam word_t PROT_CAP_WORD2 = 32'h0013_0101;
  localparam word_t PROT_CAP_WORD3 = 32'h0000_0005;

  localparam byte_t IMAGE_ACTIVATE = 8'h0F;

  // Register lengths in bytes
  localparam len_t LEN_PROT_CAP        = 16'd15;
  localparam len_t LEN_DEVICE_STATUS   = 16'd8;
  localparam len_t LEN_DEVICE_RESET    = 16'd3;
  localparam len_t LEN_RECOVERY_CTRL   = 16'd3;
  localparam len_t LEN_RECOVERY_STATUS = 16'd2;
  localparam len_t LEN_DEFAULT         = 16'd4;

endpackage

`default_nettype wire

//--- src/rec_cmd_ctrl.sv
// Command sequencer of the recovery executor, fetches write payload and launches read responses
`timescale 1ns/10ps
`default_nettype none

module rec_cmd_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              cmd_valid_i,
  input  logic              cmd_is_rd_i,
  input  rec_pkg::cmd_e     cmd_cmd_i,
  input  rec_pkg::len_t     cmd_len_i,
  input  logic              cmd_error_i,
  input  logic              rx_ack_i,
  input  rec_pkg::word_t    rx_data_i,
  input  logic              rsp_done_i,
  output logic              cmd_done_o,
  output logic              rx_req_o,
  output logic              rx_queue_clr_o,
  output logic              csr_we_o,
  output rec_pkg::csr_idx_e csr_wr_idx_o,
  output rec_pkg::word_t    csr_wr_data_o,
  output logic              status_we_o,
  output rec_pkg::proto_e   status_code_o,
  output logic              rsp_start_o,
  output rec_pkg::csr_idx_e rsp_base_o,
  output rec_pkg::len_t     rsp_len_o
);

  typedef enum logic [2:0] {
    Idle,
    Write,
    Read,
    Error,
    Done
  } state_e;

  state_e            state_d, state_q;
  rec_pkg::csr_idx_e dec_base, base_q;
  rec_pkg::len_t     dec_len, len_q;
  rec_pkg::len_t     dec_words, wcnt_q;
  rec_pkg::proto_e   proto_q;
  logic              accept, rx_take;
  logic              first_q, rsp_start_q;

  assign accept  = (state_q == Idle) & cmd_valid_i;
  assign rx_take = (state_q == Write) & rx_ack_i;

  // Payload words, length divided by four and rounded up
  assign dec_words = {2'b00, cmd_len_i[15:2]} + rec_pkg::len_t'(|cmd_len_i[1:0]);

  // Command code to register base and length
  always_comb begin
    dec_base = rec_pkg::CSR_INVALID;
    dec_len  = rec_pkg::LEN_DEFAULT;
    case (cmd_cmd_i)
      rec_pkg::CMD_PROT_CAP: begin
        dec_base = rec_pkg::CSR_PROT_CAP_0;
        dec_len  = rec_pkg::LEN_PROT_CAP;
      end
      rec_pkg::CMD_DEVICE_STATUS: begin
        dec_base = rec_pkg::CSR_DEVICE_STATUS_0;
        dec_len  = rec_pkg::LEN_DEVICE_STATUS;
      end
      rec_pkg::CMD_DEVICE_RESET: begin
        dec_base = rec_pkg::CSR_DEVICE_RESET;
        dec_len  = rec_pkg::LEN_DEVICE_RESET;
      end
      rec_pkg::CMD_RECOVERY_CTRL: begin
        dec_base = rec_pkg::CSR_RECOVERY_CTRL;
        dec_len  = rec_pkg::LEN_RECOVERY_CTRL;
      end
      rec_pkg::CMD_RECOVERY_STATUS: begin
        dec_base = rec_pkg::CSR_RECOVERY_STATUS;
        dec_len  = rec_pkg::LEN_RECOVERY_STATUS;
      end
      default: ;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (cmd_valid_i) begin
          if (cmd_error_i) state_d = Error;
          else if (cmd_is_rd_i) state_d = Read;
          else if (dec_words == '0) state_d = Done;
          else state_d = Write;
        end
      end
      Write: if (rx_take && wcnt_q == 16'd1) state_d = Done;
      Read:  if (rsp_done_i) state_d = Done;
      Error: state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= Idle;
      wcnt_q      <= '0;
      first_q     <= 1'b0;
      rsp_start_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_start_q <= accept & cmd_is_rd_i & ~cmd_error_i;
      if (accept) begin
        wcnt_q  <= dec_words;
        first_q <= 1'b1;
      end else if (rx_take) begin
        wcnt_q  <= wcnt_q - 16'd1;
        first_q <= 1'b0;
      end
    end
  end

  // Command attributes, held for the whole command
  always_ff @(posedge clk_i) begin
    if (accept) begin
      base_q <= dec_base;
      len_q  <= dec_len;
      if (cmd_error_i) proto_q <= rec_pkg::PROTO_ERROR_CRC;
      else proto_q <= rec_pkg::PROTO_OK;
    end
  end

  assign cmd_done_o     = (state_q == Done);
  assign rx_req_o       = (state_q == Write);
  assign rx_queue_clr_o = (state_q == Error);

  // Only the first payload word goes to the bank, the rest are drained
  assign csr_we_o      = rx_take & first_q;
  assign csr_wr_idx_o  = base_q;
  assign csr_wr_data_o = rx_data_i;

  assign status_we_o   = (state_q == Done);
  assign status_code_o = proto_q;

  assign rsp_start_o = rsp_start_q;
  assign rsp_base_o  = base_q;
  assign rsp_len_o   = len_q;

endmodule

`default_nettype wire

//--- src/rec_csr_bank.sv
// Recovery register bank with writability filter, protocol status update and activation detect
`timescale 1ns/10ps
`default_nettype none

module rec_csr_bank (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              csr_we_i,
  input  rec_pkg::csr_idx_e csr_wr_idx_i,
  input  rec_pkg::word_t    csr_wr_data_i,
  input  logic              status_we_i,
  input  rec_pkg::proto_e   status_code_i,
  input  rec_pkg::csr_idx_e rd_idx_i,
  output rec_pkg::word_t    rd_data_o,
  output logic              image_activated_o
);

  rec_pkg::word_t regs_q [rec_pkg::CSR_WORDS];
  logic           wr_allowed;

  // Host may only write DEVICE_RESET and RECOVERY_CTRL
  assign wr_allowed = csr_we_i &
                      ((csr_wr_idx_i == rec_pkg::CSR_DEVICE_RESET) ||
                       (csr_wr_idx_i == rec_pkg::CSR_RECOVERY_CTRL));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < rec_pkg::CSR_WORDS; i++) begin
        regs_q[i] <= '0;
      end
      regs_q[rec_pkg::CSR_PROT_CAP_0] <= rec_pkg::PROT_CAP_WORD0;
      regs_q[rec_pkg::CSR_PROT_CAP_1] <= rec_pkg::PROT_CAP_WORD1;
      regs_q[rec_pkg::CSR_PROT_CAP_2] <= rec_pkg::PROT_CAP_WORD2;
      regs_q[rec_pkg::CSR_PROT_CAP_3] <= rec_pkg::PROT_CAP_WORD3;
    end else begin
      if (wr_allowed) begin
        regs_q[csr_wr_idx_i] <= csr_wr_data_i;
      end
      // Protocol status sits in byte 1 of DEVICE_STATUS
      if (status_we_i) begin
        regs_q[rec_pkg::CSR_DEVICE_STATUS_0][15:8] <= status_code_i;
      end
    end
  end

  // Indices past the last word read as zero
  always_comb begin
    rd_data_o = '0;
    if (rd_idx_i < rec_pkg::CSR_WORDS) begin
      rd_data_o = regs_q[rd_idx_i];
    end
  end

  // Activation code lives in byte 2 of RECOVERY_CTRL
  assign image_activated_o =
    (regs_q[rec_pkg::CSR_RECOVERY_CTRL][23:16] == rec_pkg::IMAGE_ACTIVATE);

endmodule

`default_nettype wire

//--- src/rec_rsp_serializer.sv
// Read response sender that announces the length and streams register bytes little endian
`timescale 1ns/10ps
`default_nettype none

module rec_rsp_serializer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rsp_start_i,
  input  rec_pkg::csr_idx_e rsp_base_i,
  input  rec_pkg::len_t     rsp_len_i,
  input  rec_pkg::word_t    rd_data_i,
  input  logic              res_ready_i,
  input  logic              res_dready_i,
  output rec_pkg::csr_idx_e rd_idx_o,
  output logic              rsp_done_o,
  output logic              res_valid_o,
  output rec_pkg::len_t     res_len_o,
  output logic              res_dvalid_o,
  output rec_pkg::byte_t    res_data_o,
  output logic              res_dlast_o
);

  typedef enum logic [1:0] {
    Idle,
    Announce,
    Stream
  } state_e;

  state_e            state_d, state_q;
  rec_pkg::len_t     len_q, cnt_q;
  rec_pkg::csr_idx_e widx_q;
  logic              byte_take, last_byte;

  assign byte_take  = (state_q == Stream) & res_dready_i;
  assign last_byte  = (cnt_q == len_q - 16'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:     if (rsp_start_i) state_d = Announce;
      Announce: if (res_ready_i) state_d = Stream;
      Stream:   if (byte_take && last_byte) state_d = Idle;
      default:  state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == Idle && rsp_start_i) cnt_q <= '0;
      else if (byte_take) cnt_q <= cnt_q + 16'd1;
    end
  end

  // Step to the next word after byte 3 of the current one
  always_ff @(posedge clk_i) begin
    if (state_q == Idle && rsp_start_i) begin
      widx_q <= rsp_base_i;
      len_q  <= rsp_len_i;
    end else if (byte_take && cnt_q[1:0] == 2'd3) begin
      widx_q <= rec_pkg::csr_idx_e'(widx_q + 4'd1);
    end
  end

  always_comb begin
    case (cnt_q[1:0])
      2'd0:    res_data_o = rd_data_i[7:0];
      2'd1:    res_data_o = rd_data_i[15:8];
      2'd2:    res_data_o = rd_data_i[23:16];
      default: res_data_o = rd_data_i[31:24];
    endcase
  end

  assign rd_idx_o     = widx_q;
  assign res_valid_o  = (state_q == Announce);
  assign res_len_o    = len_q;
  assign res_dvalid_o = (state_q == Stream);
  assign res_dlast_o  = (state_q == Stream) & last_byte;
  assign rsp_done_o   = byte_take & last_byte;

endmodule

`default_nettype wire

//--- src/recovery_executor.sv
// Top level of the recovery command executor, wires the sequencer, register bank and sender
`timescale 1ns/10ps
`default_nettype none

module recovery_executor (
  input  logic           clk_i,
  input  logic           rst_ni,
  // Decoded command
  input  logic           cmd_valid_i,
  input  logic           cmd_is_rd_i,
  input  rec_pkg::cmd_e  cmd_cmd_i,
  input  rec_pkg::len_t  cmd_len_i,
  input  logic           cmd_error_i,
  output logic           cmd_done_o,
  // Response length and data
  output logic           res_valid_o,
  input  logic           res_ready_i,
  output rec_pkg::len_t  res_len_o,
  output logic           res_dvalid_o,
  input  logic           res_dready_i,
  output rec_pkg::byte_t res_data_o,
  output logic           res_dlast_o,
  // RX data queue
  output logic           rx_req_o,
  input  logic           rx_ack_i,
  input  rec_pkg::word_t rx_data_i,
  output logic           rx_queue_clr_o,
  output logic           image_activated_o
);

  logic              csr_we;
  rec_pkg::csr_idx_e csr_wr_idx;
  rec_pkg::word_t    csr_wr_data;
  logic              status_we;
  rec_pkg::proto_e   status_code;
  logic              rsp_start;
  rec_pkg::csr_idx_e rsp_base;
  rec_pkg::len_t     rsp_len;
  logic              rsp_done;
  rec_pkg::csr_idx_e rd_idx;
  rec_pkg::word_t    rd_data;

  rec_cmd_ctrl u_cmd_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_is_rd_i    (cmd_is_rd_i),
    .cmd_cmd_i      (cmd_cmd_i),
    .cmd_len_i      (cmd_len_i),
    .cmd_error_i    (cmd_error_i),
    .rx_ack_i       (rx_ack_i),
    .rx_data_i      (rx_data_i),
    .rsp_done_i     (rsp_done),
    .cmd_done_o     (cmd_done_o),
    .rx_req_o       (rx_req_o),
    .rx_queue_clr_o (rx_queue_clr_o),
    .csr_we_o       (csr_we),
    .csr_wr_idx_o   (csr_wr_idx),
    .csr_wr_data_o  (csr_wr_data),
    .status_we_o    (status_we),
    .status_code_o  (status_code),
    .rsp_start_o    (rsp_start),
    .rsp_base_o     (rsp_base),
    .rsp_len_o      (rsp_len)
  );

  rec_csr_bank u_csr_bank (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .csr_we_i          (csr_we),
    .csr_wr_idx_i      (csr_wr_idx),
    .csr_wr_data_i     (csr_wr_data),
    .status_we_i       (status_we),
    .status_code_i     (status_code),
    .rd_idx_i          (rd_idx),
    .rd_data_o         (rd_data),
    .image_activated_o (image_activated_o)
  );

  rec_rsp_serializer u_rsp_serializer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rsp_start_i  (rsp_start),
    .rsp_base_i   (rsp_base),
    .rsp_len_i    (rsp_len),
    .rd_data_i    (rd_data),
    .res_ready_i  (res_ready_i),
    .res_dready_i (res_dready_i),
    .rd_idx_o     (rd_idx),
    .rsp_done_o   (rsp_done),
    .res_valid_o  (res_valid_o),
    .res_len_o    (res_len_o),
    .res_dvalid_o (res_dvalid_o),
    .res_data_o   (res_data_o),
    .res_dlast_o  (res_dlast_o)
  );

endmodule

`default_nettype wire

//--- tests/recovery_executor_asserts.sv
// Protocol assertions on the executor's top-level ports, bound into recovery_executor
`timescale 1ns/10ps
`default_nettype none

module recovery_executor_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic rx_req_o,
  input logic rx_queue_clr_o,
  input logic cmd_done_o,
  input logic res_dvalid_o,
  input logic res_dlast_o
);

  // Payload fetch and response streaming never overlap
  no_rx_during_stream: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(rx_req_o && res_dvalid_o)
  ) else $error("rx_req_o and res_dvalid_o high together");

  done_one_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni) cmd_done_o |=> !cmd_done_o
  ) else $error("cmd_done_o held longer than one cycle");

  last_with_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) res_dlast_o |-> res_dvalid_o
  ) else $error("res_dlast_o without res_dvalid_o");

  // Queue clear only on errored commands, which fetch nothing
  no_clr_during_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(rx_queue_clr_o && rx_req_o)
  ) else $error("rx_queue_clr_o and rx_req_o high together");

endmodule

`default_nettype wire

//--- tests/tb_recovery_executor.sv
// Table-driven testbench for the recovery executor, runs each table row against a register model
`timescale 1ns/10ps
`default_nettype none

module tb_recovery_executor;

  typedef struct packed {
    logic           rd;
    logic [7:0]     cmd;
    rec_pkg::len_t  len;
    logic           err;
    rec_pkg::word_t w0;
    rec_pkg::word_t w1;
  } row_t;

  localparam int NUM_ROWS       = 15;
  localparam int CMD_LIMIT      = 190;
  localparam int TIMEOUT_CYCLES = 8 + 200 * NUM_ROWS;

  // Read, command code, length, error flag, payload word 0, payload word 1
  localparam row_t ROWS [NUM_ROWS] = '{
    '{1'b1, 8'd34, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd38, 16'd3, 1'b0, 32'h000F_0201, 32'h0000_0000},
    '{1'b1, 8'd38, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd38, 16'd4, 1'b0, 32'h0011_2233, 32'h0000_0000},
    '{1'b1, 8'd38, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd39, 16'd2, 1'b0, 32'hA5A5_A5A5, 32'h0000_0000},
    '{1'b1, 8'd39, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd37, 16'd8, 1'b0, 32'h00C0_FFEE, 32'h1234_5678},
    '{1'b1, 8'd37, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b1, 8'd38, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd37, 16'd4, 1'b1, 32'hDEAD_BEEF, 32'h0000_0000},
    '{1'b1, 8'd36, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b1, 8'd36, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b1, 8'd80, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000},
    '{1'b0, 8'd37, 16'd0, 1'b0, 32'h0000_0000, 32'h0000_0000}
  };

  logic           clk_i;
  logic           rst_ni;
  logic           cmd_valid_i;
  logic           cmd_is_rd_i;
  rec_pkg::cmd_e  cmd_cmd_i;
  rec_pkg::len_t  cmd_len_i;
  logic           cmd_error_i;
  logic           cmd_done_o;
  logic           res_valid_o;
  logic           res_ready_i;
  rec_pkg::len_t  res_len_o;
  logic           res_dvalid_o;
  logic           res_dready_i;
  rec_pkg::byte_t res_data_o;
  logic           res_dlast_o;
  logic           rx_req_o;
  logic           rx_ack_i;
  rec_pkg::word_t rx_data_i;
  logic           rx_queue_clr_o;
  logic           image_activated_o;

  rec_pkg::word_t model_regs [16];
  int             check_errors;
  int             other_errors;
  int             cycles;
  int             seed;

  recovery_executor UUT (.*);

  bind recovery_executor recovery_executor_asserts u_asserts (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .rx_req_o       (rx_req_o),
    .rx_queue_clr_o (rx_queue_clr_o),
    .cmd_done_o     (cmd_done_o),
    .res_dvalid_o   (res_dvalid_o),
    .res_dlast_o    (res_dlast_o)
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic check_byte(input rec_pkg::byte_t got, input rec_pkg::byte_t exp,
                            input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input rec_pkg::len_t got, input rec_pkg::len_t exp,
                           input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      check_errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Register word index of each command, 15 for unknown codes
  function automatic int base_of(input logic [7:0] cmd);
    case (cmd)
      8'd34:   return 0;
      8'd36:   return 4;
      8'd37:   return 6;
      8'd38:   return 7;
      8'd39:   return 8;
      default: return 15;
    endcase
  endfunction

  function automatic int len_of(input logic [7:0] cmd);
    case (cmd)
      8'd34:   return 15;
      8'd36:   return 8;
      8'd37:   return 3;
      8'd38:   return 3;
      8'd39:   return 2;
      default: return 4;
    endcase
  endfunction

  // Little-endian byte k of the response, words past the bank read as zero
  function automatic rec_pkg::byte_t model_byte(input int base, input int k);
    int idx;
    idx = base + k / 4;
    if (idx >= 9) return 8'h00;
    return model_regs[idx][8*(k%4) +: 8];
  endfunction

  task automatic run_command(input int r);
    row_t row;
    int   base;
    int   exp_len;
    int   exp_words;
    int   n;
    int   k;
    int   takes;
    int   clr_cnt;
    int   announces;
    int   done_n;
    logic done;
    logic req_seen;
    row       = ROWS[r];
    base      = base_of(row.cmd);
    exp_len   = len_of(row.cmd);
    exp_words = (int'(row.len) + 3) / 4;
    n         = 0;
    k         = 0;
    takes     = 0;
    clr_cnt   = 0;
    announces = 0;
    done_n    = 0;
    done      = 1'b0;
    req_seen  = 1'b0;
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_is_rd_i <= row.rd;
    cmd_cmd_i   <= rec_pkg::cmd_e'(row.cmd);
    cmd_len_i   <= row.len;
    cmd_error_i <= row.err;
    rx_data_i   <= row.w0;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    while (!done && n < CMD_LIMIT) begin
      @(posedge clk_i);
      n++;
      if (rx_req_o) begin
        if ((row.rd || row.err) && !req_seen) begin
          $display("Error at %0t: rx_req_o raised on row %0d, a read or errored command",
                   $time, r);
          other_errors++;
        end
        req_seen = 1'b1;
        // RX queue pops on each acknowledged request
        if (rx_ack_i) begin
          takes++;
          rx_data_i <= (takes == 1) ? row.w1 : 32'h0;
        end
      end
      if (rx_queue_clr_o) clr_cnt++;
      if (res_valid_o && res_ready_i) begin
        announces++;
        check_len(res_len_o, rec_pkg::len_t'(exp_len), "response length");
      end
      if (res_dvalid_o && res_dready_i) begin
        check_byte(res_data_o, model_byte(base, k), "response byte");
        check_flag(res_dlast_o, k == exp_len - 1, "res_dlast_o");
        k++;
      end
      if (cmd_done_o) begin
        done   = 1'b1;
        done_n = n;
      end
      rx_ack_i     <= ($random(seed) & 3) != 0;
      res_ready_i  <= ($random(seed) & 3) != 0;
      res_dready_i <= ($random(seed) & 3) != 0;
    end
    if (!done) begin
      $display("Error at %0t: cmd_done_o never came for row %0d", $time, r);
      other_errors++;
    end
    check_flag(clr_cnt != 0, row.err, "rx_queue_clr_o pulse");
    if (row.err) begin
      check_len(rec_pkg::len_t'(done_n), 16'd2, "errored command cycles");
    end else if (row.rd) begin
      check_len(rec_pkg::len_t'(k), rec_pkg::len_t'(exp_len), "bytes streamed");
      check_flag(announces == 1, 1'b1, "single length announce");
    end else begin
      check_len(rec_pkg::len_t'(takes), rec_pkg::len_t'(exp_words), "RX words taken");
      if (exp_words == 0) check_len(rec_pkg::len_t'(done_n), 16'd1, "zero-length write cycles");
    end
    if (!row.rd || row.err) check_flag(announces != 0, 1'b0, "response announce");
    // Only DEVICE_RESET and RECOVERY_CTRL take the first payload word
    if (!row.err && !row.rd && exp_words > 0 && (base == 6 || base == 7)) begin
      model_regs[base] = row.w0;
    end
    model_regs[4][15:8] = row.err ? 8'd4 : 8'd0;
    @(posedge clk_i);
    check_flag(image_activated_o, model_regs[7][23:16] == 8'h0F, "image_activated_o");
  endtask

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    cmd_valid_i  = 1'b0;
    cmd_is_rd_i  = 1'b0;
    cmd_cmd_i    = rec_pkg::CMD_PROT_CAP;
    cmd_len_i    = '0;
    cmd_error_i  = 1'b0;
    res_ready_i  = 1'b0;
    res_dready_i = 1'b0;
    rx_ack_i     = 1'b0;
    rx_data_i    = '0;
    check_errors = 0;
    other_errors = 0;
    cycles       = 0;
    seed         = 31;
    foreach (model_regs[i]) model_regs[i] = '0;
    model_regs[0] = rec_pkg::PROT_CAP_WORD0;
    model_regs[1] = rec_pkg::PROT_CAP_WORD1;
    model_regs[2] = rec_pkg::PROT_CAP_WORD2;
    model_regs[3] = rec_pkg::PROT_CAP_WORD3;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_command(r);
    end
    $display("Check failures: %0d, other failures: %0d", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
src/rec_pkg.sv
src/rec_cmd_ctrl.sv
src/rec_csr_bank.sv
src/rec_rsp_serializer.sv
src/recovery_executor.sv
tests/recovery_executor_asserts.sv
tests/tb_recovery_executor.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_recovery_executor
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
